//--- dv/tb_alu_cluster.sv
`timescale 1ns/1ps

module tb_alu_cluster;

    localparam int NUM_LANES = 4;
    localparam int HALF_PERIOD = 50;
    // inputs settle well before the next rising edge
    localparam int SETTLE = 10;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_RESULTS = 2000;
    // worst case per result under back-pressure
    localparam int CYCLES_PER_RESULT = 10;
    localparam int MAX_CYCLES = RESET_CYCLES + NUM_RESULTS * CYCLES_PER_RESULT;
    localparam int VALID_PCT = 70;
    localparam int READY_PCT = 60;
    localparam int BURST_PCT = 3;
    localparam int BURST_LEN = 10;
    // sink held ready, every lane drains well within this
    localparam int DRAIN_LIMIT = 4 * NUM_LANES;
    localparam logic [31:0] SEED = 32'h468;

    // one expected result plus the command that made it
    typedef struct packed {
        alu_pkg::opcode_t op;
        alu_pkg::word_t   a;
        alu_pkg::word_t   b;
        alu_pkg::word_t   result;
        logic             zero;
        logic             div_zero;
    } expect_t;

    logic             clk;
    logic             reset;
    logic             in_valid;
    logic             in_ready;
    alu_pkg::opcode_t in_opcode;
    alu_pkg::word_t   in_a;
    alu_pkg::word_t   in_b;
    logic             out_valid;
    logic             out_ready;
    alu_pkg::word_t   out_result;
    logic             out_zero;
    logic             out_div_zero;

    expect_t expect_q[$];
    int      issued = 0;
    int      results = 0;
    int      burst_left = 0;
    int      cycle_count = 0;
    // last offered command was taken
    logic    in_taken = 1'b0;

    alu_cluster_top #(
        .NUM_LANES(NUM_LANES)
    ) DUT (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_opcode    (in_opcode),
        .in_a         (in_a),
        .in_b         (in_b),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_result   (out_result),
        .out_zero     (out_zero),
        .out_div_zero (out_div_zero)
    );

    always #HALF_PERIOD clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("ERROR: run timed out after %0d cycles", cycle_count);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

    // reference ALU, unsigned, wraps to 16 bits
    function automatic alu_pkg::word_t model_result(input alu_pkg::opcode_t op,
                                                    input alu_pkg::word_t a,
                                                    input alu_pkg::word_t b);
        logic [31:0] wide;
        logic [31:0] sum;
        alu_pkg::word_t r;
        wide = {a, a};
        r = 16'd0;
        case (op)
            alu_pkg::OP_ADD: begin
                sum = 32'(a) + 32'(b);
                r = sum[15:0];
            end
            // two's complement subtract
            alu_pkg::OP_SUB: begin
                sum = 32'(a) + 32'(~b) + 32'd1;
                r = sum[15:0];
            end
            alu_pkg::OP_MUL: begin
                sum = 32'(a) * 32'(b);
                r = sum[15:0];
            end
            alu_pkg::OP_DIV:  r = (b == 16'd0) ? 16'hFFFF : a / b;
            alu_pkg::OP_SHL:  r = a << 1;
            alu_pkg::OP_SHR:  r = a >> 1;
            // rotates taken out of a doubled word
            alu_pkg::OP_ROL:  r = wide[30:15];
            alu_pkg::OP_ROR:  r = wide[16:1];
            alu_pkg::OP_AND:  r = a & b;
            alu_pkg::OP_OR:   r = a | b;
            alu_pkg::OP_XOR:  r = a ^ b;
            alu_pkg::OP_NOR:  r = ~a & ~b;
            alu_pkg::OP_NAND: r = ~a | ~b;
            alu_pkg::OP_XNOR: r = a ^ ~b;
            alu_pkg::OP_GT:   r = {15'd0, a > b};
            alu_pkg::OP_EQ:   r = {15'd0, a == b};
            default:          r = 16'd0;
        endcase
        return r;
    endfunction

    task automatic check_value(input alu_pkg::word_t actual, input alu_pkg::word_t expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s, got %h expected %h", $time, what, actual, expected);
            $display("TB FAILED");
            $fatal(1, "value check");
        end
    endtask

    task automatic fail_run(input string what);
        $display("ERROR at %0t: %s", $time, what);
        $display("TB FAILED");
        $fatal(1, "run failed");
    endtask

    // both transfers as seen just before the rising edge
    task automatic observe_transfers;
        expect_t exp;
        string   msg;
        // pop first so a stray result is caught
        if (out_valid && out_ready) begin
            if (expect_q.size() == 0) begin
                fail_run("result arrived with no command outstanding");
            end else begin
                exp = expect_q.pop_front();
                msg = $sformatf("result %0d op %h a %h b %h", results, exp.op, exp.a, exp.b);
                check_value(out_result, exp.result, {msg, " value"});
                check_value({15'd0, out_zero}, {15'd0, exp.zero}, {msg, " zero flag"});
                check_value({15'd0, out_div_zero}, {15'd0, exp.div_zero},
                            {msg, " div_zero flag"});
                results++;
            end
        end
        if (in_valid && in_ready) begin
            exp.op = in_opcode;
            exp.a = in_a;
            exp.b = in_b;
            exp.result = model_result(in_opcode, in_a, in_b);
            exp.zero = (exp.result == 16'd0);
            exp.div_zero = (in_opcode == alu_pkg::OP_DIV) && (in_b == 16'd0);
            expect_q.push_back(exp);
            issued++;
            in_taken = 1'b1;
        end else begin
            in_taken = 1'b0;
        end
        if (expect_q.size() > NUM_LANES) begin
            fail_run("more commands in flight than there are lanes");
        end
    endtask

    // one cycle of stimulus, driven on the falling edge
    task automatic drive_cycle(input int valid_pct, input logic stall);
        int pick;
        @(negedge clk);
        if (in_valid && !in_taken) begin
            // offered command waits for acceptance
        end else if (issued < NUM_RESULTS && $urandom_range(99) < valid_pct) begin
            in_valid = 1'b1;
            in_opcode = 4'($urandom_range(15));
            in_a = 16'($urandom);
            pick = int'($urandom_range(7));
            if (pick == 0) begin
                in_b = 16'd0;
            end else if (pick == 1) begin
                in_b = in_a;
            end else begin
                in_b = 16'($urandom);
            end
        end else begin
            in_valid = 1'b0;
        end
        if (stall) begin
            out_ready = 1'b0;
        end else if (burst_left > 0) begin
            out_ready = 1'b0;
            burst_left--;
        end else if ($urandom_range(99) < BURST_PCT) begin
            out_ready = 1'b0;
            burst_left = BURST_LEN - 1;
        end else begin
            out_ready = ($urandom_range(99) < READY_PCT);
        end
        #SETTLE;
        observe_transfers();
    endtask

    // no new commands, sink always ready, until nothing is outstanding
    task automatic drain_results;
        int waited;
        waited = 0;
        while (expect_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            in_valid = 1'b0;
            out_ready = 1'b1;
            #SETTLE;
            observe_transfers();
            waited++;
        end
    endtask

    // sink stalled, lanes fill one by one
    task automatic fill_lanes_check;
        int accepted;
        accepted = 0;
        repeat (NUM_LANES + 2) begin
            drive_cycle(100, 1'b1);
            if (in_taken) begin
                accepted++;
            end
        end
        check_value(16'(accepted), 16'(NUM_LANES), "commands accepted while stalled");
        check_value({15'd0, in_ready}, 16'd0, "in_ready with all lanes full");
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        in_valid = 1'b0;
        in_opcode = 4'd0;
        in_a = 16'd0;
        in_b = 16'd0;
        out_ready = 1'b0;
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        #SETTLE;
        check_value({15'd0, out_valid}, 16'd0, "out_valid after reset");
        check_value({15'd0, in_ready}, 16'd1, "in_ready after reset");
        fill_lanes_check();
        while (issued < NUM_RESULTS) begin
            drive_cycle(VALID_PCT, 1'b0);
        end
        drain_results();
        if (expect_q.size() != 0) begin
            $display("ERROR: %0d expected results never arrived", expect_q.size());
            $display("TB FAILED");
            $fatal(1, "results missing");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

//--- rtl/alu_cluster_top.sv
`timescale 1ns/1ps

module alu_cluster_top #(
    parameter int NUM_LANES = 4
) (
    input  logic             clk,
    input  logic             reset,
    // command port
    input  logic             in_valid,
    output logic             in_ready,
    input  alu_pkg::opcode_t in_opcode,
    input  alu_pkg::word_t   in_a,
    input  alu_pkg::word_t   in_b,
    // result port
    output logic             out_valid,
    input  logic             out_ready,
    output alu_pkg::word_t   out_result,
    output logic             out_zero,
    output logic             out_div_zero
);

    // dispatcher to lanes
    logic [NUM_LANES-1:0] lane_in_valid;
    logic [NUM_LANES-1:0] lane_in_ready;

    // lanes to collector
    logic           [NUM_LANES-1:0] lane_out_valid;
    logic           [NUM_LANES-1:0] lane_out_ready;
    alu_pkg::word_t [NUM_LANES-1:0] lane_result;
    logic           [NUM_LANES-1:0] lane_zero;
    logic           [NUM_LANES-1:0] lane_div_zero;

    alu_dispatch #(
        .NUM_LANES(NUM_LANES)
    ) u_dispatch (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .lane_in_valid (lane_in_valid),
        .lane_in_ready (lane_in_ready)
    );

    // opcode and operands broadcast to every lane
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        alu_lane u_lane (
            .clk          (clk),
            .reset        (reset),
            .in_valid     (lane_in_valid[g]),
            .in_ready     (lane_in_ready[g]),
            .in_opcode    (in_opcode),
            .in_a         (in_a),
            .in_b         (in_b),
            .out_valid    (lane_out_valid[g]),
            .out_ready    (lane_out_ready[g]),
            .out_result   (lane_result[g]),
            .out_zero     (lane_zero[g]),
            .out_div_zero (lane_div_zero[g])
        );
    end

    alu_collect #(
        .NUM_LANES(NUM_LANES)
    ) u_collect (
        .clk            (clk),
        .reset          (reset),
        .lane_out_valid (lane_out_valid),
        .lane_out_ready (lane_out_ready),
        .lane_result    (lane_result),
        .lane_zero      (lane_zero),
        .lane_div_zero  (lane_div_zero),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_result     (out_result),
        .out_zero       (out_zero),
        .out_div_zero   (out_div_zero)
    );

endmodule

//--- rtl/alu_collect.sv
`timescale 1ns/1ps

module alu_collect #(
    parameter int NUM_LANES = 4
) (
    input  logic                               clk,
    input  logic                               reset,
    // per-lane result slots
    input  logic           [NUM_LANES-1:0]     lane_out_valid,
    output logic           [NUM_LANES-1:0]     lane_out_ready,
    input  alu_pkg::word_t [NUM_LANES-1:0]     lane_result,
    input  logic           [NUM_LANES-1:0]     lane_zero,
    input  logic           [NUM_LANES-1:0]     lane_div_zero,
    // result handshake to the sink
    output logic                               out_valid,
    input  logic                               out_ready,
    output alu_pkg::word_t                     out_result,
    output logic                               out_zero,
    output logic                               out_div_zero
);

    // same pointer shape as the dispatcher
    localparam int PTR_W = $clog2(NUM_LANES);
    localparam logic [PTR_W-1:0] LAST_LANE = PTR_W'(NUM_LANES - 1);

    // lane holding the oldest result
    logic [PTR_W-1:0] drain_ptr;

    logic drain;

    // selected lane straight to the output
    // no register on this path
    assign out_valid    = lane_out_valid[drain_ptr];
    assign out_result   = lane_result[drain_ptr];
    assign out_zero     = lane_zero[drain_ptr];
    assign out_div_zero = lane_div_zero[drain_ptr];

    assign drain = out_valid && out_ready;

    // ready back to the selected lane only
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_out_ready[i] = out_ready && (drain_ptr == PTR_W'(i));
        end
    end

    // round-robin drain pointer
    // follows the issue order of the dispatcher
    always_ff @(posedge clk) begin
        if (reset) begin
            drain_ptr <= '0;
        end else if (drain) begin
            if (drain_ptr == LAST_LANE) begin
                drain_ptr <= '0;
            end else begin
                drain_ptr <= drain_ptr + 1'b1;
            end
        end
    end

    // a result offered and not taken is still offered next cycle
    assert property (
        @(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> out_valid
    ) else $error("out_valid dropped without a transfer");

endmodule

//--- rtl/alu_dispatch.sv
`timescale 1ns/1ps

module alu_dispatch #(
    parameter int NUM_LANES = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    // command handshake from the source
    input  logic                 in_valid,
    output logic                 in_ready,
    // per-lane handshake toward the lanes
    output logic [NUM_LANES-1:0] lane_in_valid,
    input  logic [NUM_LANES-1:0] lane_in_ready
);

    // pointer width, at least one bit since NUM_LANES >= 2
    localparam int PTR_W = $clog2(NUM_LANES);

    // index of the last lane, wrap point of the pointer
    localparam logic [PTR_W-1:0] LAST_LANE = PTR_W'(NUM_LANES - 1);

    // lane that receives the next command
    logic [PTR_W-1:0] issue_ptr;

    // command accepted this cycle
    logic accept;

    // source sees only the ready of the selected lane
    assign in_ready = lane_in_ready[issue_ptr];
    assign accept   = in_valid && in_ready;

    // steer valid to the selected lane only
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_in_valid[i] = in_valid && (issue_ptr == PTR_W'(i));
        end
    end

    // round-robin issue pointer
    // moves by one per accepted command
    always_ff @(posedge clk) begin
        if (reset) begin
            issue_ptr <= '0;
        end else if (accept) begin
            if (issue_ptr == LAST_LANE) begin
                issue_ptr <= '0;
            end else begin
                issue_ptr <= issue_ptr + 1'b1;
            end
        end
    end

    // pointer must never select a lane that does not exist
    // the collector relies on the same wrap point
    assert property (
        @(posedge clk) disable iff (reset)
        int'(issue_ptr) < NUM_LANES
    ) else $error("issue pointer out of range");

endmodule

//--- rtl/alu_lane.sv
`timescale 1ns/1ps

module alu_lane (
    input  logic             clk,
    input  logic             reset,
    // command side
    input  logic             in_valid,
    output logic             in_ready,
    input  alu_pkg::opcode_t in_opcode,
    input  alu_pkg::word_t   in_a,
    input  alu_pkg::word_t   in_b,
    // result side
    output logic             out_valid,
    input  logic             out_ready,
    output alu_pkg::word_t   out_result,
    output logic             out_zero,
    output logic             out_div_zero
);

    // combinational ALU outputs
    alu_pkg::word_t alu_result;
    logic           alu_div_zero;

    // result slot
    logic           slot_valid;
    alu_pkg::word_t slot_result;
    logic           slot_zero;
    logic           slot_div_zero;

    logic accept;

    // take a command when empty or when the slot drains this cycle
    assign in_ready = !slot_valid || out_ready;
    assign accept   = in_valid && in_ready;

    // all sixteen operations
    always_comb begin
        alu_result   = '0;
        alu_div_zero = 1'b0;
        case (in_opcode)
            alu_pkg::OP_ADD:  alu_result = in_a + in_b;
            alu_pkg::OP_SUB:  alu_result = in_a - in_b;
            // low 16 bits of the product
            alu_pkg::OP_MUL:  alu_result = in_a * in_b;
            alu_pkg::OP_DIV: begin
                if (in_b == '0) begin
                    alu_result   = alu_pkg::DIV_ZERO_RESULT;
                    alu_div_zero = 1'b1;
                end else begin
                    alu_result = in_a / in_b;
                end
            end
            alu_pkg::OP_SHL:  alu_result = {in_a[14:0], 1'b0};
            alu_pkg::OP_SHR:  alu_result = {1'b0, in_a[15:1]};
            alu_pkg::OP_ROL:  alu_result = {in_a[14:0], in_a[15]};
            alu_pkg::OP_ROR:  alu_result = {in_a[0], in_a[15:1]};
            alu_pkg::OP_AND:  alu_result = in_a & in_b;
            alu_pkg::OP_OR:   alu_result = in_a | in_b;
            alu_pkg::OP_XOR:  alu_result = in_a ^ in_b;
            alu_pkg::OP_NOR:  alu_result = ~(in_a | in_b);
            alu_pkg::OP_NAND: alu_result = ~(in_a & in_b);
            alu_pkg::OP_XNOR: alu_result = ~(in_a ^ in_b);
            // unsigned compares
            alu_pkg::OP_GT:   alu_result = (in_a > in_b) ? 16'd1 : 16'd0;
            alu_pkg::OP_EQ:   alu_result = (in_a == in_b) ? 16'd1 : 16'd0;
            default:          alu_result = '0;
        endcase
    end

    // slot occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            slot_valid <= 1'b0;
        end else if (accept) begin
            slot_valid <= 1'b1;
        end else if (out_ready) begin
            slot_valid <= 1'b0;
        end
    end

    // slot payload, loaded with the command
    always_ff @(posedge clk) begin
        if (accept) begin
            slot_result   <= alu_result;
            slot_zero     <= (alu_result == '0);
            slot_div_zero <= alu_div_zero;
        end
    end

    assign out_valid    = slot_valid;
    assign out_result   = slot_result;
    assign out_zero     = slot_zero;
    assign out_div_zero = slot_div_zero;

    // stalled result holds its contents until taken
    assert property (
        @(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=>
            (out_valid && $stable(out_result) && $stable(out_zero)
             && $stable(out_div_zero))
    ) else $error("lane slot changed while stalled");

endmodule

//--- rtl/alu_pkg.sv
package alu_pkg;

    // data word for operands and results
    typedef logic [15:0] word_t;

    // 4-bit operation code
    typedef logic [3:0] opcode_t;

    // arithmetic group
    localparam opcode_t OP_ADD  = 4'b0000;
    localparam opcode_t OP_SUB  = 4'b0001;
    localparam opcode_t OP_MUL  = 4'b0010;
    localparam opcode_t OP_DIV  = 4'b0011;
    // shifts and rotates, operand a only
    localparam opcode_t OP_SHL  = 4'b0100;
    localparam opcode_t OP_SHR  = 4'b0101;
    localparam opcode_t OP_ROL  = 4'b0110;
    localparam opcode_t OP_ROR  = 4'b0111;
    // bitwise logic
    localparam opcode_t OP_AND  = 4'b1000;
    localparam opcode_t OP_OR   = 4'b1001;
    localparam opcode_t OP_XOR  = 4'b1010;
    localparam opcode_t OP_NOR  = 4'b1011;
    localparam opcode_t OP_NAND = 4'b1100;
    localparam opcode_t OP_XNOR = 4'b1101;
    // unsigned compares, result is 1 or 0
    localparam opcode_t OP_GT   = 4'b1110;
    localparam opcode_t OP_EQ   = 4'b1111;

    // returned when dividing by zero
    localparam word_t DIV_ZERO_RESULT = 16'hFFFF;

endpackage

//--- run.sh
#!/bin/sh
# build and run the ALU cluster testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module tb_alu_cluster -Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TB PASSED$"; then
    exit 0
fi
echo "pass message not found"
exit 1

//--- src.f
rtl/alu_pkg.sv
rtl/alu_dispatch.sv
rtl/alu_lane.sv
rtl/alu_collect.sv
rtl/alu_cluster_top.sv
dv/tb_alu_cluster.sv
